// ==== design/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Processor word, cache line and address widths
`define WORD_SIZE 16
`define LINE_SIZE 64
`define ADDR_SIZE 16

// Word address split into tag, set index and word offset
`define TAG_HI  15
`define TAG_LO  3
`define IDX_BIT 2
`define OFF_HI  1
`define OFF_LO  0

// Geometry of both caches
`define WAYS 2
`define SETS 2

// Watchdog allowance per operation, in units of worst-case latency
`define WDOG_SCALE 4

`endif

// ==== design/cache_pkg.sv ====
`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`WORD_SIZE-1:0]       word_t;
    typedef logic [`ADDR_SIZE-1:0]       addr_t;

    // Word 0 of the line sits in the low bits
    typedef logic [`LINE_SIZE-1:0]       line_t;
    typedef logic [`TAG_HI-`TAG_LO:0]    tag_t;

    typedef enum logic {
        MEM_WORD,
        MEM_LINE
    } mem_size_t;

    // One request toward the shared memory port
    typedef struct packed {
        logic      read;
        logic      write;
        addr_t     addr;
        mem_size_t size;
        line_t     wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_LOOKUP,
        FETCH_FILL
    } fetch_state_t;

    typedef enum logic [2:0] {
        DC_IDLE,
        DC_READ,
        DC_WRITE,
        DC_FILL,
        DC_WR_MISS
    } data_state_t;

endpackage

// ==== design/fetch_cache.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module fetch_cache
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     i_read,
    input  addr_t    i_addr,
    output logic     o_ready,
    output word_t    o_rdata,
    output mem_req_t o_mem_req,
    input  logic     i_mem_ack,
    input  line_t    i_mem_rdata
);

    fetch_state_t state;
    addr_t        req_addr;

    logic  valid    [`WAYS][`SETS];
    logic  lru      [`WAYS][`SETS];
    tag_t  tag_mem  [`WAYS][`SETS];
    line_t data_mem [`WAYS][`SETS];

    logic                   set;
    tag_t                   req_tag;
    logic [`OFF_HI:`OFF_LO] req_off;
    logic [`WAYS-1:0]       way_hit;
    logic                   hit;
    logic                   hit_way;
    logic                   victim;
    line_t                  hit_line;
    logic                   rd_hit_en;
    logic                   fill_en;

    assign set     = req_addr[`IDX_BIT];
    assign req_tag = req_addr[`TAG_HI:`TAG_LO];
    assign req_off = req_addr[`OFF_HI:`OFF_LO];
    assign o_ready = (state == FETCH_IDLE);

    // Tag compare on both ways of the indexed set
    always_comb begin
        for (int w = 0; w < `WAYS; w++) begin
            way_hit[w] = valid[w][set] && (tag_mem[w][set] == req_tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_line = data_mem[hit_way][set];

    // Invalid way first, otherwise the LRU way
    always_comb begin
        if (!valid[0][set]) begin
            victim = 1'b0;
        end else if (!valid[1][set]) begin
            victim = 1'b1;
        end else begin
            victim = lru[1][set];
        end
    end

    assign rd_hit_en = (state == FETCH_LOOKUP) && hit;
    assign fill_en   = (state == FETCH_FILL) && i_mem_ack;

    // Line read request, held for the whole fill
    assign o_mem_req = '{read:  (state == FETCH_FILL),
                         write: 1'b0,
                         addr:  {req_addr[`ADDR_SIZE-1:`IDX_BIT], 2'b00},
                         size:  MEM_LINE,
                         wdata: '0};

    always_ff @(posedge clk) begin
        if (o_ready && i_read) begin
            req_addr <= i_addr;
        end
        if (rd_hit_en) begin
            o_rdata <= hit_line[req_off*`WORD_SIZE +: `WORD_SIZE];
        end else if (fill_en) begin
            o_rdata <= i_mem_rdata[req_off*`WORD_SIZE +: `WORD_SIZE];
        end
        if (fill_en) begin
            tag_mem[victim][set]  <= req_tag;
            data_mem[victim][set] <= i_mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= FETCH_IDLE;
            for (int w = 0; w < `WAYS; w++) begin
                for (int s = 0; s < `SETS; s++) begin
                    valid[w][s] <= 1'b0;
                    lru[w][s]   <= 1'b0;
                end
            end
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (i_read) begin
                        state <= FETCH_LOOKUP;
                    end
                end
                FETCH_LOOKUP: begin
                    if (hit) begin
                        lru[hit_way][set]  <= 1'b0;
                        lru[~hit_way][set] <= 1'b1;
                        state              <= FETCH_IDLE;
                    end else begin
                        state <= FETCH_FILL;
                    end
                end
                FETCH_FILL: begin
                    if (i_mem_ack) begin
                        valid[victim][set] <= 1'b1;
                        lru[victim][set]   <= 1'b0;
                        lru[~victim][set]  <= 1'b1;
                        state              <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

endmodule

// ==== design/data_cache.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module data_cache
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     i_read,
    input  logic     i_write,
    input  addr_t    i_addr,
    input  word_t    i_wdata,
    output logic     o_ready,
    output word_t    o_rdata,
    output mem_req_t o_mem_req,
    input  logic     i_mem_ack,
    input  line_t    i_mem_rdata
);

    data_state_t state;
    // Background line write still waiting for its ack
    logic        wr_pending;
    addr_t       req_addr;
    word_t       req_wdata;

    logic  valid    [`WAYS][`SETS];
    logic  lru      [`WAYS][`SETS];
    tag_t  tag_mem  [`WAYS][`SETS];
    line_t data_mem [`WAYS][`SETS];

    logic                   set;
    tag_t                   req_tag;
    logic [`OFF_HI:`OFF_LO] req_off;
    addr_t                  line_addr;
    logic [`WAYS-1:0]       way_hit;
    logic                   hit;
    logic                   hit_way;
    logic                   victim;
    line_t                  hit_line;
    line_t                  merged_line;
    logic                   rd_hit_en;
    logic                   wr_hit_en;
    logic                   fill_en;

    assign set       = req_addr[`IDX_BIT];
    assign req_tag   = req_addr[`TAG_HI:`TAG_LO];
    assign req_off   = req_addr[`OFF_HI:`OFF_LO];
    assign line_addr = {req_addr[`ADDR_SIZE-1:`IDX_BIT], 2'b00};
    assign o_ready   = (state == DC_IDLE);

    always_comb begin
        for (int w = 0; w < `WAYS; w++) begin
            way_hit[w] = valid[w][set] && (tag_mem[w][set] == req_tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_line = data_mem[hit_way][set];

    // Hit line with the store word dropped into its slot
    always_comb begin
        merged_line = hit_line;
        merged_line[req_off*`WORD_SIZE +: `WORD_SIZE] = req_wdata;
    end

    always_comb begin
        if (!valid[0][set]) begin
            victim = 1'b0;
        end else if (!valid[1][set]) begin
            victim = 1'b1;
        end else begin
            victim = lru[1][set];
        end
    end

    // Read hits may finish under a pending line write, writes may not
    assign rd_hit_en = (state == DC_READ) && hit;
    assign wr_hit_en = (state == DC_WRITE) && hit && !wr_pending;
    assign fill_en   = (state == DC_FILL) && i_mem_ack;

    always_ff @(posedge clk) begin
        if (o_ready && (i_read || i_write)) begin
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
        end
        if (rd_hit_en) begin
            o_rdata <= hit_line[req_off*`WORD_SIZE +: `WORD_SIZE];
        end else if (fill_en) begin
            o_rdata <= i_mem_rdata[req_off*`WORD_SIZE +: `WORD_SIZE];
        end
        if (fill_en) begin
            tag_mem[victim][set]  <= req_tag;
            data_mem[victim][set] <= i_mem_rdata;
        end else if (wr_hit_en) begin
            data_mem[hit_way][set] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state           <= DC_IDLE;
            wr_pending      <= 1'b0;
            o_mem_req.read  <= 1'b0;
            o_mem_req.write <= 1'b0;
            for (int w = 0; w < `WAYS; w++) begin
                for (int s = 0; s < `SETS; s++) begin
                    valid[w][s] <= 1'b0;
                    lru[w][s]   <= 1'b0;
                end
            end
        end else begin
            // The line write retires on its own, whatever the FSM is doing
            if (wr_pending && i_mem_ack) begin
                wr_pending      <= 1'b0;
                o_mem_req.write <= 1'b0;
            end
            case (state)
                DC_IDLE: begin
                    if (i_write) begin
                        state <= DC_WRITE;
                    end else if (i_read) begin
                        state <= DC_READ;
                    end
                end
                DC_READ: begin
                    if (hit) begin
                        lru[hit_way][set]  <= 1'b0;
                        lru[~hit_way][set] <= 1'b1;
                        state              <= DC_IDLE;
                    end else if (!wr_pending) begin
                        o_mem_req <= '{read: 1'b1, write: 1'b0, addr: line_addr,
                                       size: MEM_LINE, wdata: '0};
                        state     <= DC_FILL;
                    end
                end
                DC_WRITE: begin
                    if (wr_pending) begin
                        state <= DC_WRITE;
                    end else if (hit) begin
                        // Update in place, then push the whole line out
                        lru[hit_way][set]  <= 1'b0;
                        lru[~hit_way][set] <= 1'b1;
                        o_mem_req  <= '{read: 1'b0, write: 1'b1, addr: line_addr,
                                        size: MEM_LINE, wdata: merged_line};
                        wr_pending <= 1'b1;
                        state      <= DC_IDLE;
                    end else begin
                        // No allocate, single word at the original address
                        o_mem_req <= '{read: 1'b0, write: 1'b1, addr: req_addr,
                                       size: MEM_WORD,
                                       wdata: {{(`LINE_SIZE-`WORD_SIZE){1'b0}}, req_wdata}};
                        state     <= DC_WR_MISS;
                    end
                end
                DC_FILL: begin
                    if (i_mem_ack) begin
                        o_mem_req.read     <= 1'b0;
                        valid[victim][set] <= 1'b1;
                        lru[victim][set]   <= 1'b0;
                        lru[~victim][set]  <= 1'b1;
                        state              <= DC_IDLE;
                    end
                end
                DC_WR_MISS: begin
                    if (i_mem_ack) begin
                        o_mem_req.write <= 1'b0;
                        state           <= DC_IDLE;
                    end
                end
                default: state <= DC_IDLE;
            endcase
        end
    end

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  mem_req_t i_fetch_req,
    input  mem_req_t i_data_req,
    output logic     o_fetch_ack,
    output logic     o_data_ack,
    output mem_req_t o_mem_req,
    input  logic     i_mem_ack
);

    logic fetch_active;
    logic data_active;
    // Grant held from first request cycle until the ack
    logic grant_valid;
    logic grant_data;
    logic sel_data;

    assign fetch_active = i_fetch_req.read | i_fetch_req.write;
    assign data_active  = i_data_req.read | i_data_req.write;

    // Fresh choice only while no grant is held, data cache first
    assign sel_data = grant_valid ? grant_data : data_active;

    // Forwarded the same cycle, so no added latency
    assign o_mem_req = sel_data ? i_data_req : i_fetch_req;

    // Ack pulse goes back only to the granted side
    assign o_data_ack  = i_mem_ack & sel_data;
    assign o_fetch_ack = i_mem_ack & ~sel_data;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            grant_valid <= 1'b0;
            grant_data  <= 1'b0;
        end else if (i_mem_ack) begin
            grant_valid <= 1'b0;
        end else if (!grant_valid && (data_active || fetch_active)) begin
            grant_valid <= 1'b1;
            grant_data  <= data_active;
        end
    end

endmodule

// ==== design/mem_system.sv ====
`timescale 1ns/1ps

module mem_system
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,

    // Instruction fetch side
    input  logic     i_fetch_read,
    input  addr_t    i_fetch_addr,
    output logic     o_fetch_ready,
    output word_t    o_fetch_data,

    // Load and store side
    input  logic     i_data_read,
    input  logic     i_data_write,
    input  addr_t    i_data_addr,
    input  word_t    i_data_wdata,
    output logic     o_data_ready,
    output word_t    o_data_rdata,

    // Shared line-wide memory port
    output mem_req_t o_mem_req,
    input  logic     i_mem_ack,
    input  line_t    i_mem_rdata
);

    mem_req_t fetch_req;
    mem_req_t data_req;
    logic     fetch_ack;
    logic     data_ack;

    fetch_cache u_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_read      (i_fetch_read),
        .i_addr      (i_fetch_addr),
        .o_ready     (o_fetch_ready),
        .o_rdata     (o_fetch_data),
        .o_mem_req   (fetch_req),
        .i_mem_ack   (fetch_ack),
        .i_mem_rdata (i_mem_rdata)
    );

    data_cache u_data (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_read      (i_data_read),
        .i_write     (i_data_write),
        .i_addr      (i_data_addr),
        .i_wdata     (i_data_wdata),
        .o_ready     (o_data_ready),
        .o_rdata     (o_data_rdata),
        .o_mem_req   (data_req),
        .i_mem_ack   (data_ack),
        .i_mem_rdata (i_mem_rdata)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_fetch_req (fetch_req),
        .i_data_req  (data_req),
        .o_fetch_ack (fetch_ack),
        .o_data_ack  (data_ack),
        .o_mem_req   (o_mem_req),
        .i_mem_ack   (i_mem_ack)
    );

endmodule

// ==== bench/mem_system_props.sv ====
`timescale 1ns/1ps

module mem_system_props
    import cache_pkg::*;
(
    input logic     clk,
    input logic     reset_n,
    input mem_req_t i_mem_req,
    input logic     i_mem_ack,
    input logic     i_fetch_ready,
    input logic     i_data_ready
);

    int unsigned fail_count = 0;
    logic        req_active;

    assign req_active = i_mem_req.read | i_mem_req.write;

    // Fields frozen from the first request cycle until the ack
    req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        req_active && !i_mem_ack |=> $stable(i_mem_req))
        else begin
            fail_count++;
            $error("memory request changed before its ack");
        end

    req_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(i_mem_req.read && i_mem_req.write))
        else begin
            fail_count++;
            $error("memory read and write requested together");
        end

    // Idle caches and a quiet port right after reset
    reset_state: assert property (@(posedge clk)
        !reset_n |=> i_fetch_ready && i_data_ready && !req_active)
        else begin
            fail_count++;
            $error("caches not idle after reset");
        end

endmodule

// ==== bench/tb_mem_system.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_mem_system
    import cache_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_FETCH    = 40;
    localparam int NUM_DATA     = 80;
    // Memory latency plus a wait behind the other cache
    localparam int WORST_CYCLES = 16;
    localparam int NUM_OPS      = 2 * NUM_FETCH + NUM_DATA + 2;

    logic     clk;
    logic     reset_n;
    logic     i_fetch_read;
    addr_t    i_fetch_addr;
    logic     o_fetch_ready;
    word_t    o_fetch_data;
    logic     i_data_read;
    logic     i_data_write;
    addr_t    i_data_addr;
    word_t    i_data_wdata;
    logic     o_data_ready;
    word_t    o_data_rdata;
    mem_req_t o_mem_req;
    logic     i_mem_ack;
    line_t    i_mem_rdata;

    word_t       mem [0:65535];
    // Expected contents of the data window 0x8000 to 0x803F
    word_t       shadow [0:63];
    // Data cache tags per set, most recently used first
    tag_t        dc_tags [0:1][0:1];
    int          dc_count [0:1];
    int unsigned stim_seed  = 75748;
    int unsigned lat_seed   = 75748;
    mem_req_t    last_req;
    mem_req_t    first_req;
    logic        seen_first = 1'b0;
    addr_t       line_wr_addr;

    mem_system dut0 (.*);

    bind mem_system mem_system_props props0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_mem_req     (o_mem_req),
        .i_mem_ack     (i_mem_ack),
        .i_fetch_ready (o_fetch_ready),
        .i_data_ready  (o_data_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic int unsigned lcg_next(inout int unsigned state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state >> 8;
    endfunction

    // Predicted hit, with the LRU order updated as the cache would
    function automatic logic lookup_data_tag(input addr_t addr, input logic allocate);
        logic s;
        tag_t t;
        logic found;
        s     = addr[2];
        t     = addr[15:3];
        found = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (i < dc_count[s] && dc_tags[s][i] == t) begin
                found = 1'b1;
            end
        end
        if ((found && dc_tags[s][0] != t) || (!found && allocate)) begin
            dc_tags[s][1] = dc_tags[s][0];
            dc_tags[s][0] = t;
        end
        if (!found && allocate && dc_count[s] < 2) begin
            dc_count[s]++;
        end
        return found;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("error %s: expected %0h actual %0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // Read returns the line, writes land in memory on the ack
    task automatic serve_request(input mem_req_t req);
        line_t line;
        if (req.read) begin
            for (int i = 0; i < 4; i++) begin
                line[i*16 +: 16] = mem[req.addr + i];
            end
            i_mem_rdata = line;
        end else if (req.size == MEM_WORD) begin
            mem[req.addr] = req.wdata[15:0];
        end else begin
            check_value("line write address", line_wr_addr, req.addr);
            for (int i = 0; i < 4; i++) begin
                check_value("line write word", shadow[req.addr[5:0] + i], req.wdata[i*16 +: 16]);
                mem[req.addr + i] = req.wdata[i*16 +: 16];
            end
        end
    endtask

    initial begin : memory_model
        int       lat;
        mem_req_t req;
        forever begin
            @(negedge clk);
            i_mem_ack = 1'b0;
            req = o_mem_req;
            if (reset_n && (req.read || req.write)) begin
                if (!seen_first) begin
                    first_req  = req;
                    seen_first = 1'b1;
                end
                lat = int'(lcg_next(lat_seed) % 4) + 1;
                repeat (lat - 1) @(negedge clk);
                serve_request(req);
                last_req  = req;
                i_mem_ack = 1'b1;
            end
        end
    end

    // Starts and ends on a falling edge
    task automatic fetch_op(input addr_t addr, output int edges, output logic saw_req);
        edges   = 1;
        saw_req = 1'b0;
        check_value("fetch ready at request", 1, o_fetch_ready);
        i_fetch_read = 1'b1;
        i_fetch_addr = addr;
        @(negedge clk);
        i_fetch_read = 1'b0;
        while (!o_fetch_ready) begin
            saw_req |= o_mem_req.read | o_mem_req.write;
            @(negedge clk);
            edges++;
        end
        check_value("fetch data", addr ^ 16'h5A5A, o_fetch_data);
    endtask

    task automatic data_op(input logic wr, input addr_t addr, input word_t wdata,
                           output int edges);
        addr_t line_addr;
        logic  hit;
        line_addr = {addr[15:2], 2'b00};
        edges     = 1;
        if (wr) begin
            while (o_mem_req.read || o_mem_req.write) begin
                @(negedge clk);
            end
            shadow[addr[5:0]] = wdata;
            line_wr_addr      = line_addr;
            last_req          = '0;
        end
        hit = lookup_data_tag(addr, !wr);
        check_value("data ready at request", 1, o_data_ready);
        i_data_read  = !wr;
        i_data_write = wr;
        i_data_addr  = addr;
        i_data_wdata = wdata;
        @(negedge clk);
        i_data_read  = 1'b0;
        i_data_write = 1'b0;
        while (!o_data_ready) begin
            @(negedge clk);
            edges++;
        end
        if (hit) begin
            check_value("data hit latency", 2, edges);
        end
        if (!wr) begin
            check_value("data read", shadow[addr[5:0]], o_data_rdata);
        end else if (hit) begin
            check_value("write hit line request", {1'b1, MEM_LINE, line_addr},
                        {o_mem_req.write, o_mem_req.size, o_mem_req.addr});
        end else begin
            check_value("write miss word request", {1'b1, MEM_WORD, addr},
                        {last_req.write, last_req.size, last_req.addr});
            check_value("write miss word data", {48'h0, wdata}, last_req.wdata);
        end
    endtask

    initial begin
        int unsigned r;
        addr_t       a;
        int          edges;
        int          edges_f;
        logic        saw_req;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 16'(i) ^ 16'h5A5A;
        end
        for (int i = 0; i < 64; i++) begin
            shadow[i] = 16'(16'h8000 + i) ^ 16'h5A5A;
        end
        dc_count[0]  = 0;
        dc_count[1]  = 0;
        reset_n      = 1'b0;
        i_fetch_read = 1'b0;
        i_fetch_addr = '0;
        i_data_read  = 1'b0;
        i_data_write = 1'b0;
        i_data_addr  = '0;
        i_data_wdata = '0;
        i_mem_ack    = 1'b0;
        i_mem_rdata  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Both caches miss in the same cycle
        fork
            fetch_op(16'h1234, edges_f, saw_req);
            data_op(1'b0, 16'h8010, 16'h0000, edges);
        join
        check_value("arbitration first request", {1'b1, 16'h8010},
                    {first_req.read, first_req.addr});

        for (int n = 0; n < NUM_FETCH; n++) begin
            r = lcg_next(stim_seed);
            a = r[7] ? addr_t'(r[21:8]) : addr_t'(r[12:8]);
            fetch_op(a, edges, saw_req);
            // Same address again right away must hit
            fetch_op(a, edges, saw_req);
            check_value("fetch hit latency", 2, edges);
            check_value("fetch hit memory request", 0, saw_req);
        end

        for (int n = 0; n < NUM_DATA; n++) begin
            r = lcg_next(stim_seed);
            data_op(r[6], 16'h8000 | addr_t'(r[5:0]), word_t'(r[23:8]), edges);
        end

        while (o_mem_req.read || o_mem_req.write) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (dut0.props0.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("memory port assertions failed %0d times", dut0.props0.fail_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

    initial begin
        #(NUM_OPS * WORST_CYCLES * `WDOG_SCALE * CLK_PERIOD);
        $display("watchdog expired before all operations finished");
        $display("TEST FAILED");
        $fatal(1, "simulation timeout");
    end

endmodule

// ==== project.f ====
+incdir+design
design/cache_pkg.sv
design/fetch_cache.sv
design/data_cache.sv
design/mem_arbiter.sv
design/mem_system.sv
bench/mem_system_props.sv
bench/tb_mem_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_system -f project.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
